/* all.f */
source/valu_pkg.sv
source/valu_decode.sv
source/valu_arith.sv
source/valu_bitwise.sv
source/valu_top.sv
dv/valu_checker.sv
dv/valu_tb.sv

/* dv/valu_checker.sv */
`default_nettype none

module valu_checker #(
    parameter int LINES = 1,
    parameter int COLS  = 13
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  valu_pkg::valu_resp_t resp,
    output int                   done_count,
    output int                   pass_count,
    output int                   fail_count
);

    logic [63:0] golden [0:LINES*COLS-1];
    logic [1:0]  pend_v;    // One bit per cycle of DUT latency
    int          pend_idx [2];
    int          accepted;

    task automatic compare_line(input int n);
        int   base;
        int   errs;
        logic exp_valid;
        base      = n * COLS + 8; // Expected columns start here
        errs      = 0;
        exp_valid = golden[base][0];
        if (resp.valid !== exp_valid) begin
            errs++;
            if (exp_valid)
                $display("test %0d: response missing, resp.valid stayed low", n);
            else
                $display("test %0d: response appeared for an unrecognised function id", n);
        end
        if (resp.data !== golden[base+1]) begin
            errs++;
            $display("ERROR test %0d resp.data expected %h got %h", n, golden[base+1], resp.data);
        end
        if (resp.side.addr !== golden[base+2][valu_pkg::ADDR_WIDTH-1:0]) begin
            errs++;
            $display("ERROR test %0d resp.addr expected %h got %h", n,
                     golden[base+2][valu_pkg::ADDR_WIDTH-1:0], resp.side.addr);
        end
        if (resp.side.vl !== golden[base+3][valu_pkg::VL_WIDTH-1:0]) begin
            errs++;
            $display("ERROR test %0d resp.vl expected %h got %h", n,
                     golden[base+3][valu_pkg::VL_WIDTH-1:0], resp.side.vl);
        end
        if (resp.side.be !== golden[base+4][valu_pkg::BE_WIDTH-1:0]) begin
            errs++;
            $display("ERROR test %0d resp.be expected %h got %h", n,
                     golden[base+4][valu_pkg::BE_WIDTH-1:0], resp.side.be);
        end
        if (errs == 0) begin
            pass_count++;
            $display("test %0d: ok", n);
        end else begin
            fail_count++;
            $display("test %0d: mismatch", n);
        end
        done_count++;
    endtask

    initial begin
        $readmemh("dv/valu_golden.hex", golden);
        pend_v     = '0;
        accepted   = 0;
        done_count = 0;
        pass_count = 0;
        fail_count = 0;
        forever begin
            @(posedge clk);
            pend_v      = {pend_v[0], req_valid && !rst};
            pend_idx[1] = pend_idx[0];
            if (req_valid && !rst) begin
                pend_idx[0] = accepted;
                accepted++;
            end
            @(negedge clk); // Response registers have settled
            if (!rst) begin
                if (pend_v[1]) begin
                    compare_line(pend_idx[1]);
                end else if (resp.valid !== 1'b0) begin
                    fail_count++;
                    $display("Unexpected response: resp.valid is high with no request in flight");
                end
            end
        end
    end

endmodule

`default_nettype wire

/* dv/valu_golden.hex */
// fn sew mask be data0 data1 addr vl, then expected: valid data addr vl be
// sew: 0=8 1=16 2=32 3=64 bits
00 0 0 ff ff01807f00fe1020 01ff800101030f10 00001000 08 1 0000008001011f30 00001000 08 ff
00 1 0 ff ff01807f00fe1020 01ff800101030f10 00001010 04 1 0100008002011f30 00001010 04 ff
00 2 0 ff ff01807f00fe1020 01ff800101030f10 00001020 02 1 0101008002011f30 00001020 02 ff
00 3 0 ff 00000000ffffffff 0000000000000001 00001030 01 1 0000000100000000 00001030 01 ff
02 0 0 ff 00107f80ff010520 0110807f01020321 00001040 08 1 ff00ff01feff02ff 00001040 08 ff
02 1 0 ff 00107f80ff010520 0110807f01020321 00001050 04 1 ff00ff01fdff01ff 00001050 04 ff
02 2 0 ff 00107f80ff010520 0110807f01020321 00001060 02 1 feffff01fdff01ff 00001060 02 ff
02 3 0 ff 00107f80ff010520 0110807f01020321 00001070 01 1 feffff01fdff01ff 00001070 01 ff
03 0 0 ff 00107f80ff010520 0110807f01020321 00001080 08 1 010001ff0201fe01 00001080 08 ff
03 1 0 ff 00107f80ff010520 0110807f01020321 00001090 04 1 010000ff0201fe01 00001090 04 ff
03 2 0 ff 00107f80ff010520 0110807f01020321 000010a0 02 1 010000ff0200fe01 000010a0 02 ff
03 3 0 ff 00107f80ff010520 0110807f01020321 000010b0 01 1 010000fe0200fe01 000010b0 01 ff
04 0 0 ff 8000ff7f01fe1090 00807fff817e2010 000010c0 08 1 00007f7f017e1010 000010c0 08 ff
05 0 0 ff 8000ff7f01fe1090 00807fff817e2010 000010d0 08 1 8080ffff81fe1090 000010d0 08 ff
06 0 0 ff 8000ff7f01fe1090 00807fff817e2010 000010e0 08 1 8080ffff81fe2090 000010e0 08 ff
07 0 0 ff 8000ff7f01fe1090 00807fff817e2010 000010f0 08 1 00007f7f017e2010 000010f0 08 ff
04 2 0 ff 800000017fffffff 00000001ffffffff 00001100 02 1 000000017fffffff 00001100 02 ff
05 2 0 ff 800000017fffffff 00000001ffffffff 00001110 02 1 80000001ffffffff 00001110 02 ff
06 2 0 ff 800000017fffffff 00000001ffffffff 00001120 02 1 80000001ffffffff 00001120 02 ff
07 2 0 ff 800000017fffffff 00000001ffffffff 00001130 02 1 000000017fffffff 00001130 02 ff
09 3 0 ff f0f0ff0012345678 ff000f0fffff0000 00001140 01 1 f0000f0012340000 00001140 01 ff
0a 3 0 ff f0f0ff0012345678 ff000f0fffff0000 00001150 01 1 fff0ff0fffff5678 00001150 01 ff
0b 3 0 ff f0f0ff0012345678 ff000f0fffff0000 00001160 01 1 0ff0f00fedcb5678 00001160 01 ff
17 0 0 a5 0011223344556677 8899aabbccddeeff 00001170 08 1 009922bbcc55ee77 00001170 08 a5
17 0 0 0f 0011223344556677 8899aabbccddeeff 00001180 08 1 8899aabb44556677 00001180 08 0f
17 0 1 3c 0011223344556677 8899aabbccddeeff 00001190 08 1 0011223344556677 00001190 08 3c
// Back to back block, the 3f id is unrecognised
00 0 0 ff ff01807f00fe1020 01ff800101030f10 000011a0 08 1 0000008001011f30 000011a0 08 ff
3f 0 0 55 ff01807f00fe1020 01ff800101030f10 000011b0 08 0 0000000000000000 000011b0 08 55
0b 3 0 ff f0f0ff0012345678 ff000f0fffff0000 000011c0 01 1 0ff0f00fedcb5678 000011c0 01 ff
07 0 0 ff 8000ff7f01fe1090 00807fff817e2010 000011d0 08 1 00007f7f017e2010 000011d0 08 ff

/* dv/valu_tb.sv */
`default_nettype none

module valu_tb;

    localparam int LINES       = 30;
    localparam int COLS        = 13;
    localparam int BURST_START = 26; // Lines from here on follow each other with no gap
    localparam int PERIOD      = 100;

    logic                 clk;
    logic                 rst;
    logic                 req_valid;
    valu_pkg::valu_req_t  req;
    valu_pkg::valu_resp_t resp;
    logic [63:0]          golden [0:LINES*COLS-1];
    int unsigned          lcg_state;
    int                   done_count;
    int                   pass_count;
    int                   fail_count;

    valu_top #(
        .MIN_MAX_ENABLE (1)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .resp      (resp)
    );

    valu_checker #(
        .LINES (LINES),
        .COLS  (COLS)
    ) u_checker (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .resp       (resp),
        .done_count (done_count),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic drive_line(input int n);
        int base;
        base          = n * COLS;
        req.func_id   = golden[base][valu_pkg::FUNC_WIDTH-1:0];
        req.sew       = valu_pkg::sew_e'(golden[base+1][1:0]);
        req.mask      = golden[base+2][0];
        req.be        = golden[base+3][valu_pkg::BE_WIDTH-1:0];
        req.data0     = golden[base+4];
        req.data1     = golden[base+5];
        req.addr      = golden[base+6][valu_pkg::ADDR_WIDTH-1:0];
        req.vl        = golden[base+7][valu_pkg::VL_WIDTH-1:0];
        req_valid     = 1'b1;
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        int gap;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        lcg_state = 32'd51447;
        $readmemh("dv/valu_golden.hex", golden);
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int n = 0; n < LINES; n++) begin
            drive_line(n);
            @(negedge clk);
            req_valid = 1'b0;
            lcg_state = lcg_next(lcg_state);
            gap = (n >= BURST_START - 1) ? 0 : int'((lcg_state >> 16) % 3);
            repeat (gap) @(negedge clk);
        end
        wait (done_count == LINES);
        repeat (3) @(negedge clk); // Catch stray valids after the last response
        $display("%0d tests passed, %0d failures", pass_count, fail_count);
        if (fail_count == 0 && pass_count == LINES)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        #(PERIOD * (LINES * 3 + 20));
        $display("Timeout: the run did not finish in the expected number of cycles");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Compile and run the VALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f all.f --top-module valu_tb -o valu_sim --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/valu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASSED" sim.log; then
    exit 0
fi
exit 1

/* source/valu_arith.sv */
`default_nettype none

module valu_arith #(
    parameter int MIN_MAX_ENABLE = 1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  en,
    input  valu_pkg::arith_op_e   op,
    input  valu_pkg::sew_e        sew,
    input  valu_pkg::vec_word_u   data0,
    input  valu_pkg::vec_word_u   data1,
    output valu_pkg::unit_out_t   out
);

    localparam int DW = valu_pkg::DATA_WIDTH;

    valu_pkg::vec_word_u res;

    // One element; a and b zero extended, sa and sb sign extended
    function automatic logic [DW-1:0] lane_calc(
        input valu_pkg::arith_op_e op_i,
        input logic [DW-1:0]       a,
        input logic [DW-1:0]       b,
        input logic [DW-1:0]       sa,
        input logic [DW-1:0]       sb
    );
        logic lt_u;
        logic lt_s;
        lt_u = 1'b0;
        lt_s = 1'b0;
        if (MIN_MAX_ENABLE != 0) begin // Comparators drop out otherwise
            lt_u = a < b;
            lt_s = $signed(sa) < $signed(sb);
        end
        case (op_i)
            valu_pkg::ADD:  lane_calc = a + b;
            valu_pkg::SUB:  lane_calc = a - b;
            valu_pkg::RSUB: lane_calc = b - a;
            valu_pkg::MINU: lane_calc = lt_u ? a : b;
            valu_pkg::MIN:  lane_calc = lt_s ? a : b;
            valu_pkg::MAXU: lane_calc = lt_u ? b : a;
            valu_pkg::MAX:  lane_calc = lt_s ? b : a;
            default:        lane_calc = '0;
        endcase
    endfunction

    // Truncating each lane keeps carries inside the element
    always_comb begin
        res = '0;
        case (sew)
            valu_pkg::SEW_8: begin
                for (int i = 0; i < DW / 8; i++) begin
                    res.b[i] = 8'(lane_calc(op, DW'(data0.b[i]), DW'(data1.b[i]),
                                            DW'($signed(data0.b[i])),
                                            DW'($signed(data1.b[i]))));
                end
            end
            valu_pkg::SEW_16: begin
                for (int i = 0; i < DW / 16; i++) begin
                    res.h[i] = 16'(lane_calc(op, DW'(data0.h[i]), DW'(data1.h[i]),
                                             DW'($signed(data0.h[i])),
                                             DW'($signed(data1.h[i]))));
                end
            end
            valu_pkg::SEW_32: begin
                for (int i = 0; i < DW / 32; i++) begin
                    res.w[i] = 32'(lane_calc(op, DW'(data0.w[i]), DW'(data1.w[i]),
                                             DW'($signed(data0.w[i])),
                                             DW'($signed(data1.w[i]))));
                end
            end
            default: begin
                res.d = lane_calc(op, data0.d, data1.d, data0.d, data1.d);
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out <= '0;
        end else begin
            out.valid <= en;
            out.data  <= en ? res.d : '0; // Idle unit drives zeros for the OR merge
        end
    end

    assert property (@(posedge clk) disable iff (rst) out.valid |-> $past(en));

endmodule

`default_nettype wire

/* source/valu_bitwise.sv */
`default_nettype none

module valu_bitwise (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           en,
    input  valu_pkg::bit_op_e              op,
    input  logic [valu_pkg::BE_WIDTH-1:0]  be,
    input  valu_pkg::vec_word_u            data0,
    input  valu_pkg::vec_word_u            data1,
    output valu_pkg::unit_out_t            out
);

    valu_pkg::vec_word_u res;

    always_comb begin
        res = '0;
        case (op)
            valu_pkg::AND: res.d = data0.d & data1.d;
            valu_pkg::OR:  res.d = data0.d | data1.d;
            valu_pkg::XOR: res.d = data0.d ^ data1.d;
            valu_pkg::MERGE: begin
                for (int i = 0; i < valu_pkg::BE_WIDTH; i++) begin
                    res.b[i] = be[i] ? data0.b[i] : data1.b[i]; // Per byte select
                end
            end
            valu_pkg::MOVE: res = data0;
            default:        res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out <= '0;
        end else begin
            out.valid <= en;
            out.data  <= en ? res.d : '0;
        end
    end

    assert property (@(posedge clk) disable iff (rst) out.valid |-> $past(en));

endmodule

`default_nettype wire

/* source/valu_decode.sv */
`default_nettype none

module valu_decode #(
    parameter int MIN_MAX_ENABLE = 1
) (
    input  logic                             req_valid,
    input  logic [valu_pkg::FUNC_WIDTH-1:0]  func_id,
    input  logic                             mask,
    output valu_pkg::unit_sel_t              sel
);

    localparam logic MM_EN = (MIN_MAX_ENABLE != 0);

    function automatic valu_pkg::unit_sel_t arith_sel(input valu_pkg::arith_op_e op,
                                                      input logic en);
        arith_sel          = '0;
        arith_sel.arith_en = en;
        arith_sel.arith_op = op;
    endfunction

    function automatic valu_pkg::unit_sel_t bit_sel(input valu_pkg::bit_op_e op);
        bit_sel        = '0;
        bit_sel.bit_en = 1'b1;
        bit_sel.bit_op = op;
    endfunction

    always_comb begin
        sel = '0; // Unknown ids select no unit
        if (req_valid) begin
            case (func_id)
                valu_pkg::FN_ADD:  sel = arith_sel(valu_pkg::ADD, 1'b1);
                valu_pkg::FN_SUB:  sel = arith_sel(valu_pkg::SUB, 1'b1);
                valu_pkg::FN_RSUB: sel = arith_sel(valu_pkg::RSUB, 1'b1);
                valu_pkg::FN_MINU: sel = arith_sel(valu_pkg::MINU, MM_EN);
                valu_pkg::FN_MIN:  sel = arith_sel(valu_pkg::MIN, MM_EN);
                valu_pkg::FN_MAXU: sel = arith_sel(valu_pkg::MAXU, MM_EN);
                valu_pkg::FN_MAX:  sel = arith_sel(valu_pkg::MAX, MM_EN);
                valu_pkg::FN_AND:  sel = bit_sel(valu_pkg::AND);
                valu_pkg::FN_OR:   sel = bit_sel(valu_pkg::OR);
                valu_pkg::FN_XOR:  sel = bit_sel(valu_pkg::XOR);
                valu_pkg::FN_MERGE_MOVE: begin
                    if (mask)
                        sel = bit_sel(valu_pkg::MOVE);
                    else
                        sel = bit_sel(valu_pkg::MERGE);
                end
                default: sel = '0;
            endcase
        end
    end

    // The top ORs unit outputs, so two active units would corrupt the result
    always_comb begin
        assert (!(sel.arith_en && sel.bit_en));
    end

endmodule

`default_nettype wire

/* source/valu_pkg.sv */
`default_nettype none

package valu_pkg;

    parameter int DATA_WIDTH = 64;
    parameter int BE_WIDTH   = DATA_WIDTH / 8;
    parameter int ADDR_WIDTH = 32;
    parameter int VL_WIDTH   = 8;
    parameter int FUNC_WIDTH = 6;

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_e;

    localparam logic [FUNC_WIDTH-1:0] FN_ADD        = 6'b000000;
    localparam logic [FUNC_WIDTH-1:0] FN_SUB        = 6'b000010;
    localparam logic [FUNC_WIDTH-1:0] FN_RSUB       = 6'b000011;
    localparam logic [FUNC_WIDTH-1:0] FN_MINU       = 6'b000100;
    localparam logic [FUNC_WIDTH-1:0] FN_MIN        = 6'b000101;
    localparam logic [FUNC_WIDTH-1:0] FN_MAXU       = 6'b000110;
    localparam logic [FUNC_WIDTH-1:0] FN_MAX        = 6'b000111;
    localparam logic [FUNC_WIDTH-1:0] FN_AND        = 6'b001001;
    localparam logic [FUNC_WIDTH-1:0] FN_OR         = 6'b001010;
    localparam logic [FUNC_WIDTH-1:0] FN_XOR        = 6'b001011;
    localparam logic [FUNC_WIDTH-1:0] FN_MERGE_MOVE = 6'b010111; // Mask bit picks move

    // One operand word, read in the lane view given by SEW
    typedef union packed {
        logic [DATA_WIDTH/8-1:0][7:0]   b;
        logic [DATA_WIDTH/16-1:0][15:0] h;
        logic [DATA_WIDTH/32-1:0][31:0] w;
        logic [DATA_WIDTH-1:0]          d;
    } vec_word_u;

    typedef enum logic [2:0] {ADD, SUB, RSUB, MINU, MIN, MAXU, MAX} arith_op_e;
    typedef enum logic [2:0] {AND, OR, XOR, MERGE, MOVE} bit_op_e;

    typedef struct packed {
        logic [FUNC_WIDTH-1:0] func_id;
        sew_e                  sew;
        logic                  mask;
        logic [BE_WIDTH-1:0]   be;
        vec_word_u             data0;
        vec_word_u             data1;
        logic [ADDR_WIDTH-1:0] addr;
        logic [VL_WIDTH-1:0]   vl;
    } valu_req_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [VL_WIDTH-1:0]   vl;
        logic [BE_WIDTH-1:0]   be;
    } valu_side_t;

    typedef struct packed {
        logic      arith_en;
        arith_op_e arith_op;
        logic      bit_en;
        bit_op_e   bit_op;
    } unit_sel_t;

    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] data;
    } unit_out_t;

    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] data;
        valu_side_t            side;
    } valu_resp_t;

endpackage

`default_nettype wire

/* source/valu_top.sv */
`default_nettype none

module valu_top #(
    parameter int MIN_MAX_ENABLE = 1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    input  valu_pkg::valu_req_t    req,
    output valu_pkg::valu_resp_t   resp
);

    valu_pkg::unit_sel_t  sel;
    valu_pkg::unit_out_t  arith_out;
    valu_pkg::unit_out_t  bit_out;
    valu_pkg::valu_side_t side_q;

    valu_decode #(
        .MIN_MAX_ENABLE (MIN_MAX_ENABLE)
    ) u_decode (
        .req_valid (req_valid),
        .func_id   (req.func_id),
        .mask      (req.mask),
        .sel       (sel)
    );

    valu_arith #(
        .MIN_MAX_ENABLE (MIN_MAX_ENABLE)
    ) u_arith (
        .clk   (clk),
        .rst   (rst),
        .en    (sel.arith_en),
        .op    (sel.arith_op),
        .sew   (req.sew),
        .data0 (req.data0),
        .data1 (req.data1),
        .out   (arith_out)
    );

    valu_bitwise u_bitwise (
        .clk   (clk),
        .rst   (rst),
        .en    (sel.bit_en),
        .op    (sel.bit_op),
        .be    (req.be),
        .data0 (req.data0),
        .data1 (req.data1),
        .out   (bit_out)
    );

    // Sideband matches the unit stage so it lines up with the result
    always_ff @(posedge clk) begin
        if (rst) begin
            side_q <= '0;
        end else begin
            side_q.addr <= req.addr;
            side_q.vl   <= req.vl;
            side_q.be   <= req.be;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp <= '0;
        end else begin
            resp.valid <= arith_out.valid | bit_out.valid;
            resp.data  <= arith_out.data | bit_out.data; // At most one unit is active
            resp.side  <= side_q;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !$isunknown(resp.valid));

endmodule

`default_nettype wire
